//--- source/gsu_pkg.sv
`default_nettype none

package gsu_pkg;

  // ----------------------------------------
  // Console address map
  // ----------------------------------------

  // R0..R15, two bytes each, low byte first
  localparam logic [23:0] reg_base_addr   = 24'h003000;

  // Status/flag register byte addresses
  localparam logic [23:0] sfr_lo_addr     = 24'h003030;
  localparam logic [23:0] sfr_hi_addr     = 24'h003031;

  // Code cache window, size set by cache_addr_w
  localparam logic [23:0] cache_base_addr = 24'h003100;

  // ----------------------------------------
  // SFR bit positions
  // ----------------------------------------
  localparam int sfr_z_bit   = 1;
  localparam int sfr_cy_bit  = 2;
  localparam int sfr_s_bit   = 3;
  localparam int sfr_go_bit  = 5;
  localparam int sfr_irq_bit = 15;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  localparam logic [7:0] op_stop     = 8'h00;
  localparam logic [7:0] op_nop      = 8'h01;

  // Groups, high nibble of the opcode byte
  localparam logic [3:0] op_to_grp   = 4'h1;
  localparam logic [3:0] op_add_grp  = 4'h5;
  localparam logic [3:0] op_sub_grp  = 4'h6;
  localparam logic [3:0] op_ibt_grp  = 4'hA;
  localparam logic [3:0] op_from_grp = 4'hB;

endpackage

`default_nettype wire

//--- source/gsu_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Register access and run control, MMIO <-> core
interface gsu_reg_if;

  // Console side register write
  logic        reg_wr;
  logic [3:0]  reg_idx;
  logic [15:0] reg_wdata;

  // Register selected by reg_idx, combinational
  logic [15:0] reg_rdata;

  // Run control
  logic        go;
  logic        stop;   // one-cycle pulse on STOP

  // Core flags for SFR readback
  logic        z;
  logic        cy;
  logic        s;

  modport mmio (
    output reg_wr, reg_idx, reg_wdata, go,
    input  reg_rdata, stop, z, cy, s
  );

  modport core (
    input  reg_wr, reg_idx, reg_wdata, go,
    output reg_rdata, stop, z, cy, s
  );

endinterface

`default_nettype wire

//--- source/gsu_cache.sv
`timescale 1ns/1ps
`default_nettype none

// Code cache, one write port from the console and one read port for fetch
module gsu_cache #(
  parameter int cache_addr_w = 9
) (
  input  wire                    clk,

  // Write port, console side
  input  wire                    cache_we,
  input  wire [cache_addr_w-1:0] cache_waddr,
  input  wire [7:0]              cache_wdata,

  // Read port, fetch side
  input  wire [cache_addr_w-1:0] cache_raddr,
  output logic [7:0]             cache_rdata
);

  localparam int depth = 2 ** cache_addr_w;

  logic [7:0] mem [depth];

  always_ff @(posedge clk) begin
    if (cache_we) begin
      mem[cache_waddr] <= cache_wdata;
    end
  end

  // Registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    cache_rdata <= mem[cache_raddr];
  end

endmodule

`default_nettype wire

//--- source/gsu_mmio.sv
`timescale 1ns/1ps
`default_nettype none

// Console bus decode, SFR and run/interrupt flags
module gsu_mmio #(
  parameter int cache_addr_w = 9
) (
  input  wire                     clk,
  input  wire                     rst_n,

  // Console bus
  input  wire                     enable,
  input  wire                     snes_rd_start,
  input  wire                     snes_wr_end,
  input  wire  [23:0]             snes_addr,
  input  wire  [7:0]              data_in,
  output logic [7:0]              data_out,
  output logic                    irq,

  // Cache write port
  output logic                    cache_we,
  output logic [cache_addr_w-1:0] cache_waddr,
  output logic [7:0]              cache_wdata,

  gsu_reg_if.mmio                 bus
);

  localparam logic [23:0] cache_size = 24'(1) << cache_addr_w;

  logic        wr_stb;
  logic        rd_stb;
  logic        reg_hit;
  logic        sfr_lo_hit;
  logic        sfr_hi_hit;
  logic        cache_hit;
  logic [23:0] cache_off;
  logic [7:0]  lo_latch;
  logic [15:0] sfr;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign wr_stb     = enable & snes_wr_end;
  assign rd_stb     = enable & snes_rd_start;

  // 32-byte register block, aligned
  assign reg_hit    = snes_addr[23:5] == gsu_pkg::reg_base_addr[23:5];
  assign sfr_lo_hit = snes_addr == gsu_pkg::sfr_lo_addr;
  assign sfr_hi_hit = snes_addr == gsu_pkg::sfr_hi_addr;

  assign cache_off  = snes_addr - gsu_pkg::cache_base_addr;
  assign cache_hit  = (snes_addr >= gsu_pkg::cache_base_addr) && (cache_off < cache_size);

  // ----------------------------------------
  // Register writes
  // ----------------------------------------

  // Even address holds the low byte until the odd write
  always_ff @(posedge clk) begin
    if (wr_stb && reg_hit && !snes_addr[0]) begin
      lo_latch <= data_in;
    end
  end

  assign bus.reg_wr    = wr_stb & reg_hit & snes_addr[0];
  assign bus.reg_idx   = snes_addr[4:1];
  assign bus.reg_wdata = {data_in, lo_latch};

  // Program loads only while stopped
  assign cache_we    = wr_stb & cache_hit & ~bus.go;
  assign cache_waddr = cache_off[cache_addr_w-1:0];
  assign cache_wdata = data_in;

  // ----------------------------------------
  // Run and interrupt flags
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.go <= 1'b0;
    end else if (bus.stop) begin
      bus.go <= 1'b0;
    end else if (wr_stb && sfr_lo_hit && !data_in[gsu_pkg::sfr_go_bit]) begin
      // Abort from the console
      bus.go <= 1'b0;
    end else if (bus.reg_wr && bus.reg_idx == 4'hF) begin
      bus.go <= 1'b1;
    end
  end

  // Set wins over a clearing read in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else if (bus.stop) begin
      irq <= 1'b1;
    end else if (rd_stb && sfr_hi_hit) begin
      irq <= 1'b0;
    end
  end

  // SFR image
  always_comb begin
    sfr                       = '0;
    sfr[gsu_pkg::sfr_z_bit]   = bus.z;
    sfr[gsu_pkg::sfr_cy_bit]  = bus.cy;
    sfr[gsu_pkg::sfr_s_bit]   = bus.s;
    sfr[gsu_pkg::sfr_go_bit]  = bus.go;
    sfr[gsu_pkg::sfr_irq_bit] = irq;
  end

  // ----------------------------------------
  // Readback
  // ----------------------------------------

  // Captured on read start, held until the next read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out <= 8'h00;
    end else if (rd_stb) begin
      if (reg_hit) begin
        data_out <= snes_addr[0] ? bus.reg_rdata[15:8] : bus.reg_rdata[7:0];
      end else if (sfr_lo_hit) begin
        data_out <= sfr[7:0];
      end else if (sfr_hi_hit) begin
        data_out <= sfr[15:8];
      end else begin
        data_out <= 8'h00;   // unmapped or write-only
      end
    end
  end

endmodule

`default_nettype wire

//--- source/gsu_core.sv
`timescale 1ns/1ps
`default_nettype none

// Register file and fetch/execute sequencer
module gsu_core #(
  parameter int cache_addr_w = 9
) (
  input  wire                     clk,
  input  wire                     rst_n,

  // Cache read port
  output logic [cache_addr_w-1:0] cache_raddr,
  input  wire  [7:0]              cache_rdata,

  gsu_reg_if.core                 bus
);

  // Sequencer states
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_fetch = 2'd1;
  localparam logic [1:0] st_exec  = 2'd2;
  localparam logic [1:0] st_imm   = 2'd3;

  logic [1:0]  state;
  logic [15:0] regs [16];
  logic [3:0]  sreg;
  logic [3:0]  dreg;
  logic [3:0]  imm_idx;
  logic        z_q;
  logic        cy_q;
  logic        s_q;

  logic [3:0]  op_grp;
  logic [3:0]  op_n;
  logic        is_exec;
  logic [15:0] src_val;
  logic [15:0] opnd_val;
  logic [16:0] alu_sum;
  logic [16:0] alu_diff;

  // ----------------------------------------
  // Decode and ALU
  // ----------------------------------------
  assign op_grp  = cache_rdata[7:4];
  assign op_n    = cache_rdata[3:0];
  assign is_exec = bus.go && (state == st_exec);

  always_comb begin
    src_val  = regs[sreg];
    opnd_val = regs[op_n];
    alu_sum  = {1'b0, src_val} + {1'b0, opnd_val};
    alu_diff = {1'b0, src_val} - {1'b0, opnd_val};
  end

  // PC is R15, always presented to the cache
  assign cache_raddr = regs[15][cache_addr_w-1:0];

  assign bus.stop      = is_exec && (cache_rdata == gsu_pkg::op_stop);
  assign bus.reg_rdata = regs[bus.reg_idx];
  assign bus.z         = z_q;
  assign bus.cy        = cy_q;
  assign bus.s         = s_q;

  // Target of a pending IBT
  always_ff @(posedge clk) begin
    if (is_exec && op_grp == gsu_pkg::op_ibt_grp) begin
      imm_idx <= op_n;
    end
  end

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'h0000;
      end
      state <= st_idle;
      sreg  <= 4'h0;
      dreg  <= 4'h0;
      z_q   <= 1'b0;
      cy_q  <= 1'b0;
      s_q   <= 1'b0;
    end else if (!bus.go) begin
      // Stopped or aborted, console owns the registers
      state <= st_idle;
      sreg  <= 4'h0;
      dreg  <= 4'h0;
      if (bus.reg_wr) begin
        regs[bus.reg_idx] <= bus.reg_wdata;
      end
    end else begin
      case (state)
        st_idle: begin
          state <= st_fetch;
        end

        // Opcode address already on the cache
        st_fetch: begin
          regs[15] <= regs[15] + 16'd1;
          state    <= st_exec;
        end

        st_exec: begin
          state <= st_fetch;
          case (op_grp)
            gsu_pkg::op_to_grp: begin
              dreg <= op_n;
            end
            gsu_pkg::op_from_grp: begin
              sreg <= op_n;
            end
            gsu_pkg::op_add_grp: begin
              regs[dreg] <= alu_sum[15:0];
              z_q        <= alu_sum[15:0] == 16'h0000;
              s_q        <= alu_sum[15];
              cy_q       <= alu_sum[16];
              sreg       <= 4'h0;
              dreg       <= 4'h0;
            end
            gsu_pkg::op_sub_grp: begin
              regs[dreg] <= alu_diff[15:0];
              z_q        <= alu_diff[15:0] == 16'h0000;
              s_q        <= alu_diff[15];
              cy_q       <= ~alu_diff[16];   // set when no borrow
              sreg       <= 4'h0;
              dreg       <= 4'h0;
            end
            gsu_pkg::op_ibt_grp: begin
              // Immediate read issued this cycle
              regs[15] <= regs[15] + 16'd1;
              state    <= st_imm;
              sreg     <= 4'h0;
              dreg     <= 4'h0;
            end
            default: begin
              // STOP, NOP and unknown opcodes
              sreg <= 4'h0;
              dreg <= 4'h0;
              if (cache_rdata == gsu_pkg::op_stop) begin
                state <= st_idle;
              end
            end
          endcase
        end

        // Immediate byte on cache_rdata
        st_imm: begin
          regs[imm_idx] <= {{8{cache_rdata[7]}}, cache_rdata};
          state         <= st_fetch;
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/gsu.sv
`timescale 1ns/1ps
`default_nettype none

// GSU subset, cartridge side of the console bus
module gsu #(
  parameter int cache_addr_w = 9
) (
  input  wire        clk,
  input  wire        rst_n,

  // Console bus
  input  wire        enable,
  input  wire        snes_rd_start,
  input  wire        snes_wr_end,
  input  wire [23:0] snes_addr,
  input  wire [7:0]  data_in,
  output logic [7:0] data_out,
  output logic       irq
);

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------
  gsu_reg_if reg_bus ();

  logic                    cache_we;
  logic [cache_addr_w-1:0] cache_waddr;
  logic [7:0]              cache_wdata;
  logic [cache_addr_w-1:0] cache_raddr;
  logic [7:0]              cache_rdata;

  // ----------------------------------------
  // MMIO
  // ----------------------------------------
  gsu_mmio #(
    .cache_addr_w (cache_addr_w)
  ) u_mmio (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .snes_rd_start (snes_rd_start),
    .snes_wr_end   (snes_wr_end),
    .snes_addr     (snes_addr),
    .data_in       (data_in),
    .data_out      (data_out),
    .irq           (irq),
    .cache_we      (cache_we),
    .cache_waddr   (cache_waddr),
    .cache_wdata   (cache_wdata),
    .bus           (reg_bus.mmio)
  );

  // ----------------------------------------
  // Code cache
  // ----------------------------------------
  gsu_cache #(
    .cache_addr_w (cache_addr_w)
  ) u_cache (
    .clk         (clk),
    .cache_we    (cache_we),
    .cache_waddr (cache_waddr),
    .cache_wdata (cache_wdata),
    .cache_raddr (cache_raddr),
    .cache_rdata (cache_rdata)
  );

  // ----------------------------------------
  // Execution pipeline
  // ----------------------------------------
  gsu_core #(
    .cache_addr_w (cache_addr_w)
  ) u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .cache_raddr (cache_raddr),
    .cache_rdata (cache_rdata),
    .bus         (reg_bus.core)
  );

endmodule

`default_nettype wire

//--- testbench/gsu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Bus and run-control properties of the gsu top level
module gsu_assertions #(
  parameter int cache_addr_w = 9
) (
  input wire                    clk,
  input wire                    rst_n,
  input wire                    enable,
  input wire                    snes_rd_start,
  input wire [7:0]              data_out,
  input wire                    irq,
  input wire                    go,
  input wire [cache_addr_w-1:0] cache_raddr
);

  // Failed assertions so far, summed into the final result
  int fail_count = 0;

  // Reset leaves the run and interrupt flags low
  a_reset_flags: assert property (@(posedge clk) !rst_n |=> (!irq && !go))
    else begin
      $error("irq or go high in the cycle after reset");
      fail_count++;
    end

  // Fetch address known during a run
  a_fetch_known: assert property (@(posedge clk) disable iff (!rst_n)
    go |-> !$isunknown(cache_raddr))
    else begin
      $error("cache_raddr unknown while go is high");
      fail_count++;
    end

  // Readback only moves after a read start
  a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(enable && snes_rd_start) |-> $stable(data_out))
    else begin
      $error("data_out changed without a read");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- testbench/tb_gsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gsu;

  localparam int cache_addr_w = 9;
  localparam int n_progs      = 8;
  localparam int irq_timeout  = 2000;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic        snes_rd_start;
  logic        snes_wr_end;
  logic [23:0] snes_addr;
  logic [7:0]  data_in;
  wire  [7:0]  data_out;
  wire         irq;

  int          seed = 32'hdd195d6f;
  int          errors;
  int          tests_run;
  int          tests_failed;

  // Reference model state
  logic [15:0] m_r [16];
  logic        m_z;
  logic        m_cy;
  logic        m_s;
  logic [7:0]  prog [$];

  // ----------------------------------------
  // Program table, first byte on top
  // ----------------------------------------
  logic [63:0] prog_tbl [n_progs] = '{
    64'h5200_0000_0000_0000,   // ADD R2 into R0
    64'h13B1_5200_0000_0000,   // R3 = R1 + R2
    64'h14B5_6600_0000_0000,   // R4 = R5 - R6
    64'hB767_0000_0000_0000,   // R0 = R7 - R7, zero
    64'hA835_A9C8_0000_0000,   // IBT positive and negative
    64'hA17F_12B1_5101_0000,   // R2 = 0x7F + 0x7F
    64'hA380_15B3_6400_0000,   // R5 = 0xFF80 - R4
    64'h1601_5100_0000_0000    // NOP drops the TO
  };
  int          len_tbl [n_progs] = '{2, 4, 4, 3, 5, 7, 6, 4};

  gsu #(
    .cache_addr_w (cache_addr_w)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .snes_rd_start (snes_rd_start),
    .snes_wr_end   (snes_wr_end),
    .snes_addr     (snes_addr),
    .data_in       (data_in),
    .data_out      (data_out),
    .irq           (irq)
  );

  bind gsu gsu_assertions #(.cache_addr_w(cache_addr_w)) u_assertions (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .snes_rd_start (snes_rd_start),
    .data_out      (data_out),
    .irq           (irq),
    .go            (reg_bus.go),
    .cache_raddr   (cache_raddr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // Console bus access
  // ----------------------------------------
  task automatic bus_write(input logic [23:0] addr, input logic [7:0] data);
    @(negedge clk);
    enable      = 1'b1;
    snes_wr_end = 1'b1;
    snes_addr   = addr;
    data_in     = data;
    @(negedge clk);
    enable      = 1'b0;
    snes_wr_end = 1'b0;
  endtask

  // Data sampled one cycle after the strobe
  task automatic bus_read(input logic [23:0] addr, output logic [7:0] data);
    @(negedge clk);
    enable        = 1'b1;
    snes_rd_start = 1'b1;
    snes_addr     = addr;
    @(negedge clk);
    enable        = 1'b0;
    snes_rd_start = 1'b0;
    data          = data_out;
  endtask

  // Low byte latched, odd address commits
  task automatic reg_write(input int idx, input logic [15:0] val);
    bus_write(gsu_pkg::reg_base_addr + 24'(2 * idx), val[7:0]);
    bus_write(gsu_pkg::reg_base_addr + 24'(2 * idx + 1), val[15:8]);
  endtask

  task automatic reg_read(input int idx, output logic [15:0] val);
    logic [7:0] lo;
    logic [7:0] hi;
    bus_read(gsu_pkg::reg_base_addr + 24'(2 * idx), lo);
    bus_read(gsu_pkg::reg_base_addr + 24'(2 * idx + 1), hi);
    val = {hi, lo};
  endtask

  task automatic load_program(input logic [15:0] start);
    for (int i = 0; i < prog.size(); i++) begin
      bus_write(gsu_pkg::cache_base_addr + 24'(start) + 24'(i), prog[i]);
    end
  endtask

  // ----------------------------------------
  // Reference model of the instruction rules
  // ----------------------------------------
  task automatic model_run(input logic [15:0] start);
    int          pc;
    logic [3:0]  sr;
    logic [3:0]  dr;
    logic [3:0]  n;
    logic [7:0]  op;
    logic [7:0]  imm;
    logic [16:0] res;
    logic        arith;
    logic        done;
    pc   = 0;
    sr   = 4'h0;
    dr   = 4'h0;
    done = 1'b0;
    while (!done && pc < prog.size()) begin
      op    = prog[pc];
      n     = op[3:0];
      arith = 1'b0;
      pc++;
      if (op == gsu_pkg::op_stop) begin
        done = 1'b1;
      end else if (op[7:4] == gsu_pkg::op_to_grp) begin
        dr = n;
      end else if (op[7:4] == gsu_pkg::op_from_grp) begin
        sr = n;
      end else begin
        if (op[7:4] == gsu_pkg::op_add_grp) begin
          res   = {1'b0, m_r[sr]} + {1'b0, m_r[n]};
          m_cy  = res[16];
          arith = 1'b1;
        end else if (op[7:4] == gsu_pkg::op_sub_grp) begin
          res   = {1'b0, m_r[sr]} - {1'b0, m_r[n]};
          m_cy  = m_r[sr] >= m_r[n];   // no borrow
          arith = 1'b1;
        end else if (op[7:4] == gsu_pkg::op_ibt_grp) begin
          imm    = prog[pc];
          m_r[n] = {{8{imm[7]}}, imm};
          pc++;
        end
        if (arith) begin
          m_r[dr] = res[15:0];
          m_z     = res[15:0] == 16'h0000;
          m_s     = res[15];
        end
        // Selectors fall back to R0
        sr = 4'h0;
        dr = 4'h0;
      end
    end
    m_r[15] = start + 16'(pc);
  endtask

  // ----------------------------------------
  // Checks and reporting
  // ----------------------------------------
  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic wait_for_irq();
    int n;
    n = 0;
    while (irq !== 1'b1 && n < irq_timeout) begin
      @(negedge clk);
      n++;
    end
    if (irq !== 1'b1) begin
      $display("timeout: irq did not rise within %0d cycles", irq_timeout);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  endtask

  // SFR high read returns the flag and drops irq
  task automatic clear_irq();
    logic [7:0] b;
    bus_read(gsu_pkg::sfr_hi_addr, b);
    check_value("sfr irq", 16'(b[gsu_pkg::sfr_irq_bit - 8]), 16'h0001);
    check_value("irq", 16'(irq), 16'h0000);
  endtask

  task automatic verify_state();
    logic [15:0] rv;
    logic [7:0]  b;
    for (int i = 0; i < 16; i++) begin
      reg_read(i, rv);
      check_value($sformatf("r%0d", i), rv, m_r[i]);
    end
    bus_read(gsu_pkg::sfr_lo_addr, b);
    check_value("sfr z", 16'(b[gsu_pkg::sfr_z_bit]), 16'(m_z));
    check_value("sfr cy", 16'(b[gsu_pkg::sfr_cy_bit]), 16'(m_cy));
    check_value("sfr s", 16'(b[gsu_pkg::sfr_s_bit]), 16'(m_s));
    check_value("sfr go", 16'(b[gsu_pkg::sfr_go_bit]), 16'h0000);
  endtask

  task automatic randomize_regs();
    logic [31:0] rnd;
    for (int i = 0; i < 15; i++) begin
      rnd    = $random(seed);
      m_r[i] = rnd[15:0];
      reg_write(i, m_r[i]);
    end
  endtask

  task automatic run_program(input logic [15:0] start);
    model_run(start);
    reg_write(15, start);
    wait_for_irq();
    clear_irq();
    verify_state();
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [15:0] rv;
    logic [7:0]  b;
    logic [15:0] start;
    int          e0;
    enable        = 1'b0;
    snes_rd_start = 1'b0;
    snes_wr_end   = 1'b0;
    snes_addr     = 24'h000000;
    data_in       = 8'h00;
    rst_n         = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    m_z           = 1'b0;
    m_cy          = 1'b0;
    m_s           = 1'b0;
    for (int i = 0; i < 16; i++) begin
      m_r[i] = 16'h0000;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Readback of R0..R14
    e0 = errors;
    randomize_regs();
    for (int i = 0; i < 15; i++) begin
      reg_read(i, rv);
      check_value($sformatf("r%0d", i), rv, m_r[i]);
    end
    report_test("register readback", e0);

    // GO while running, cleared at the end
    e0 = errors;
    prog.delete();
    repeat (6) prog.push_back(gsu_pkg::op_nop);
    prog.push_back(gsu_pkg::op_stop);
    load_program(16'h0000);
    model_run(16'h0000);
    reg_write(15, 16'h0000);
    bus_read(gsu_pkg::sfr_lo_addr, b);
    check_value("sfr go", 16'(b[gsu_pkg::sfr_go_bit]), 16'h0001);
    wait_for_irq();
    bus_read(gsu_pkg::sfr_lo_addr, b);
    check_value("sfr go", 16'(b[gsu_pkg::sfr_go_bit]), 16'h0000);
    clear_irq();
    verify_state();
    report_test("run start and stop", e0);

    // Table programs against the model
    for (int t = 0; t < n_progs; t++) begin
      e0 = errors;
      randomize_regs();
      prog.delete();
      for (int i = 0; i < len_tbl[t]; i++) begin
        prog.push_back(prog_tbl[t][63 - 8 * i -: 8]);
      end
      start = 16'h0020 + 16'(t * 24);
      load_program(start);
      run_program(start);
      report_test($sformatf("program %0d", t), e0);
    end

    // Writes during a long run have no effect
    e0 = errors;
    prog.delete();
    prog.push_back(8'hA4);
    prog.push_back(8'h11);
    prog.push_back(gsu_pkg::op_stop);
    load_program(16'h01C0);
    prog.delete();
    repeat (40) prog.push_back(gsu_pkg::op_nop);
    prog.push_back(gsu_pkg::op_stop);
    load_program(16'h0100);
    model_run(16'h0100);
    reg_write(15, 16'h0100);
    reg_write(3, ~m_r[3]);
    bus_write(gsu_pkg::cache_base_addr + 24'h0001C1, 8'h22);
    check_value("irq", 16'(irq), 16'h0000);
    wait_for_irq();
    clear_irq();
    verify_state();
    // Immediate byte must still be 0x11
    prog.delete();
    prog.push_back(8'hA4);
    prog.push_back(8'h11);
    prog.push_back(gsu_pkg::op_stop);
    run_program(16'h01C0);
    report_test("writes ignored while running", e0);

    // irq cleared by SFR high read only
    e0 = errors;
    prog.delete();
    prog.push_back(gsu_pkg::op_stop);
    load_program(16'h0180);
    model_run(16'h0180);
    reg_write(15, 16'h0180);
    wait_for_irq();
    bus_read(gsu_pkg::sfr_lo_addr, b);
    check_value("irq", 16'(irq), 16'h0001);
    clear_irq();
    repeat (10) begin
      @(negedge clk);
      check_value("irq", 16'(irq), 16'h0000);
    end
    run_program(16'h0180);
    report_test("irq clear", e0);

    $display("tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, DUT.u_assertions.fail_count);
    if (errors == 0 && DUT.u_assertions.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/gsu_pkg.sv
source/gsu_reg_if.sv
source/gsu_cache.sv
source/gsu_mmio.sv
source/gsu_core.sv
source/gsu.sv
testbench/gsu_assertions.sv
testbench/tb_gsu.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_gsu
FILELIST = vlog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+1000
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
